// File: verilog/ecc_params.svh
// memory window start address, depth in words and error counter width
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// byte address of the first word of the scratchpad
`define CCM_SADR 32'hF004_0000

// number of 32-bit words, window size is four times this and a power of two
`define CCM_DEPTH 64

// width of the single and double error counters
`define ERR_CNT_W 16

`endif

// File: verilog/ecc_pkg.sv
// data, check-bit, index and codeword types plus the hamming parity masks
`include "ecc_params.svh"

package ecc_pkg;

   localparam int IDX_W = $clog2(`CCM_DEPTH);

   typedef logic [31:0]      data_t;
   typedef logic [6:0]       ecc_t;   // bit 6 overall parity, 5..0 hamming
   typedef logic [IDX_W-1:0] idx_t;   // word index, address bits above bit 1

   typedef struct packed {
      ecc_t  ecc;
      data_t data;
   } code_s;

   // one stored word, seen as fields by the codec and as a flat vector by
   // the injection and scrub paths
   typedef union packed {
      code_s       f;
      logic [38:0] flat;
   } code_u;

   // data bits covered by each hamming check bit
   localparam logic [5:0][31:0] H_MASK = {
      32'hFC00_0000,   // check bit 5
      32'h03FF_F800,   // check bit 4
      32'h03FC_07F0,   // check bit 3
      32'hE3C3_C78E,   // check bit 2
      32'h9B33_366D,   // check bit 1
      32'h56AA_AD5B    // check bit 0
   };

endpackage

// File: verilog/ccm_rd_if.sv
// read result bundle from the memory bank to the response stage
interface ccm_rd_if;

   logic           valid;      // one cycle per read
   ecc_pkg::code_u code;       // raw stored codeword
   ecc_pkg::idx_t  idx;        // word index, returned for scrubbing
   logic           in_range;   // address hit the memory window

   // bank side drives the registered read
   modport bank (
      output valid,
      output code,
      output idx,
      output in_range
   );

   // response side decodes it
   modport resp (
      input valid,
      input code,
      input idx,
      input in_range
   );

endinterface

// File: verilog/ecc_encode.sv
// SECDED check-bit generator for one 32-bit data word
module ecc_encode (
   input  ecc_pkg::data_t data,
   output ecc_pkg::ecc_t  ecc
);

   logic [5:0] ham;       // hamming check bits
   logic       overall;   // parity over data and hamming bits

   // six parity trees, each over its own subset of data bits
   always_comb begin
      for (int i = 0; i < 6; i++) begin
         ham[i] = ^(data & ecc_pkg::H_MASK[i]);
      end
   end

   // overall parity makes the whole 39-bit word even,
   // which separates single from double errors on decode
   assign overall = (^data) ^ (^ham);

   assign ecc = {overall, ham};

endmodule

// File: verilog/ecc_decode.sv
// SECDED syndrome, single-bit correction and error classification
module ecc_decode (
   input  ecc_pkg::code_u code,
   output ecc_pkg::data_t data,
   output ecc_pkg::ecc_t  ecc,
   output logic           single_err,
   output logic           double_err
);

   logic [6:0]  chk;        // syndrome in 5..0, overall parity mismatch in 6
   logic [38:0] err_mask;   // one-hot flip for hamming positions 1..39
   logic [38:0] pos_in;     // word spread into hamming positions
   logic [38:0] pos_out;

   // recompute each check bit and compare with the stored one
   always_comb begin
      for (int i = 0; i < 6; i++) begin
         chk[i] = code.f.ecc[i] ^ (^(code.f.data & ecc_pkg::H_MASK[i]));
      end
      chk[6] = (^code.f.data) ^ (^code.f.ecc);
   end

   // odd overall parity means one bit flipped, even parity with a
   // nonzero syndrome means two
   assign single_err = (chk != 7'd0) &  chk[6];
   assign double_err = (chk != 7'd0) & ~chk[6];

   always_comb begin
      for (int i = 1; i < 40; i++) begin
         err_mask[i-1] = (chk[5:0] == 6'(i));
      end
   end

   // check bits sit at the power-of-two positions, overall parity on top
   assign pos_in = {code.f.ecc[6],
                    code.f.data[31:26],
                    code.f.ecc[5],
                    code.f.data[25:11],
                    code.f.ecc[4],
                    code.f.data[10:4],
                    code.f.ecc[3],
                    code.f.data[3:1],
                    code.f.ecc[2],
                    code.f.data[0],
                    code.f.ecc[1:0]};

   // only a single error is corrected, a double passes through as stored
   assign pos_out = single_err ? (pos_in ^ err_mask) : pos_in;

   // gather the data bits back out of the hamming positions
   assign data = {pos_out[37:32],
                  pos_out[30:16],
                  pos_out[14:8],
                  pos_out[6:4],
                  pos_out[2]};

   // syndrome zero with bad parity means the parity bit itself flipped
   assign ecc = {pos_out[38] ^ (chk == 7'b100_0000),
                 pos_out[31],
                 pos_out[15],
                 pos_out[7],
                 pos_out[3],
                 pos_out[1:0]};

endmodule

// File: verilog/ccm_bank.sv
// codeword array with range check, write arbitration, error injection and registered read
`include "ecc_params.svh"

module ccm_bank (
   input  logic           clk,
   input  logic           rst_l,
   input  logic           wr_en,
   input  logic           rd_en,
   input  logic [31:0]    addr,
   input  ecc_pkg::data_t wdata,
   input  ecc_pkg::code_u inject,      // bits flipped on the stored word
   input  logic           fix_valid,   // scrub request from the response stage
   input  ecc_pkg::idx_t  fix_idx,
   input  ecc_pkg::code_u fix_code,
   output logic           addr_err_wr,
   ccm_rd_if.bank         rd
);

   // byte address bits that select a word inside the window
   localparam int          WIN_BITS = $clog2(`CCM_DEPTH * 4);
   localparam logic [31:0] SADR     = `CCM_SADR;

   ecc_pkg::code_u mem [`CCM_DEPTH];

   logic           in_range;
   ecc_pkg::idx_t  idx;
   ecc_pkg::ecc_t  wr_ecc;
   ecc_pkg::code_u host_code;
   logic           host_we;
   logic           scrub_we;
   ecc_pkg::idx_t  wr_idx;
   logic [38:0]    wr_word;

   // window is aligned to its size, so an upper bit compare is enough
   assign in_range = (addr[31:WIN_BITS] == SADR[31:WIN_BITS]);
   assign idx      = addr[WIN_BITS-1:2];

   ecc_encode i_enc (
      .data (wdata),
      .ecc  (wr_ecc)
   );

   always_comb begin
      host_code.f.data = wdata;
      host_code.f.ecc  = wr_ecc;
   end

   // one write port, a host write always beats a pending scrub
   assign host_we  = wr_en & in_range;
   assign scrub_we = fix_valid & ~wr_en;   // dropped even if the host write misses
   assign wr_idx   = wr_en ? idx : fix_idx;

   // the injection mask lands on the flat view, data and check bits alike
   assign wr_word  = wr_en ? (host_code.flat ^ inject.flat) : fix_code.flat;

   always_ff @(posedge clk) begin
      if (host_we | scrub_we) begin
         mem[wr_idx].flat <= wr_word;
      end
   end

   // read data is captured only when a read is issued
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd.code     <= mem[idx];
         rd.idx      <= idx;
         rd.in_range <= in_range;
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd.valid    <= 1'b0;
         addr_err_wr <= 1'b0;
      end else begin
         rd.valid    <= rd_en;
         addr_err_wr <= wr_en & ~in_range;   // out of window write is dropped
      end
   end

endmodule

// File: verilog/ccm_resp.sv
// read decode stage with registered response, saturating error counters and scrub request
`include "ecc_params.svh"

module ccm_resp (
   input  logic                  clk,
   input  logic                  rst_l,
   ccm_rd_if.resp                rd,
   output logic                  rd_valid,
   output ecc_pkg::data_t        rd_data,
   output logic                  single_err,
   output logic                  double_err,
   output logic                  rd_addr_err,
   output logic [`ERR_CNT_W-1:0] single_cnt,
   output logic [`ERR_CNT_W-1:0] double_cnt,
   output logic                  fix_valid,
   output ecc_pkg::idx_t         fix_idx,
   output ecc_pkg::code_u        fix_code
);

   ecc_pkg::data_t dec_data;
   ecc_pkg::ecc_t  dec_ecc;
   logic           dec_single;
   logic           dec_double;
   logic           hit;          // valid read inside the window
   logic           hit_single;
   logic           hit_double;

   // counter step that sticks at all ones
   function automatic logic [`ERR_CNT_W-1:0] sat_inc(
      input logic [`ERR_CNT_W-1:0] cnt,
      input logic                  inc
   );
      sat_inc = (inc && !(&cnt)) ? cnt + 1'b1 : cnt;
   endfunction

   ecc_decode i_dec (
      .code       (rd.code),
      .data       (dec_data),
      .ecc        (dec_ecc),
      .single_err (dec_single),
      .double_err (dec_double)
   );

   // error flags mean nothing for an address outside the window
   assign hit        = rd.valid & rd.in_range;
   assign hit_single = hit & dec_single;
   assign hit_double = hit & dec_double;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_valid    <= 1'b0;
         rd_addr_err <= 1'b0;
         single_err  <= 1'b0;
         double_err  <= 1'b0;
         fix_valid   <= 1'b0;
         single_cnt  <= '0;
         double_cnt  <= '0;
      end else begin
         rd_valid    <= rd.valid;
         rd_addr_err <= rd.valid & ~rd.in_range;
         single_err  <= hit_single;
         double_err  <= hit_double;
         fix_valid   <= hit_single;   // write the corrected word back
         single_cnt  <= sat_inc(single_cnt, hit_single);
         double_cnt  <= sat_inc(double_cnt, hit_double);
      end
   end

   // response data is zero for an out of range read
   always_ff @(posedge clk) begin
      if (rd.valid) begin
         rd_data <= rd.in_range ? dec_data : '0;
      end
   end

   // scrub payload holds the corrected data and corrected check bits
   always_ff @(posedge clk) begin
      if (hit_single) begin
         fix_idx         <= rd.idx;
         fix_code.f.data <= dec_data;
         fix_code.f.ecc  <= dec_ecc;
      end
   end

endmodule

// File: verilog/ccm_top.sv
// scratchpad top level joining the memory bank and the read response stage
`include "ecc_params.svh"

module ccm_top (
   input  logic                  clk,
   input  logic                  rst_l,
   input  logic                  wr_en,
   input  logic                  rd_en,
   input  logic [31:0]           addr,
   input  ecc_pkg::data_t        wdata,
   input  logic [38:0]           inject,   // 31..0 data, 38..32 check bits
   output logic                  rd_valid,
   output ecc_pkg::data_t        rd_data,
   output logic                  single_err,
   output logic                  double_err,
   output logic                  addr_err,
   output logic [`ERR_CNT_W-1:0] single_cnt,
   output logic [`ERR_CNT_W-1:0] double_cnt
);

   logic           fix_valid;
   ecc_pkg::idx_t  fix_idx;
   ecc_pkg::code_u fix_code;
   ecc_pkg::code_u inject_code;
   logic           rd_addr_err;
   logic           addr_err_wr;

   ccm_rd_if rd_bus ();

   assign inject_code.flat = inject;

   ccm_bank i_bank (
      .clk         (clk),
      .rst_l       (rst_l),
      .wr_en       (wr_en),
      .rd_en       (rd_en),
      .addr        (addr),
      .wdata       (wdata),
      .inject      (inject_code),
      .fix_valid   (fix_valid),
      .fix_idx     (fix_idx),
      .fix_code    (fix_code),
      .addr_err_wr (addr_err_wr),
      .rd          (rd_bus.bank)
   );

   ccm_resp i_resp (
      .clk         (clk),
      .rst_l       (rst_l),
      .rd          (rd_bus.resp),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .single_err  (single_err),
      .double_err  (double_err),
      .rd_addr_err (rd_addr_err),
      .single_cnt  (single_cnt),
      .double_cnt  (double_cnt),
      .fix_valid   (fix_valid),
      .fix_idx     (fix_idx),
      .fix_code    (fix_code)
   );

   // one access per cycle, so the read and write flags never overlap
   assign addr_err = rd_addr_err | addr_err_wr;

endmodule

// File: bench/ccm_tb.sv
// testbench for the scratchpad with clock, reset, lfsr, compare tasks and directed tests
`include "ecc_params.svh"

module ccm_tb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef logic [`ERR_CNT_W-1:0] cnt_t;

   localparam logic [31:0] SADR      = `CCM_SADR;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

   logic           clk;
   logic           rst_l;
   logic           wr_en;
   logic           rd_en;
   logic [31:0]    addr;
   ecc_pkg::data_t wdata;
   logic [38:0]    inject;
   logic           rd_valid;
   ecc_pkg::data_t rd_data;
   logic           single_err;
   logic           double_err;
   logic           addr_err;
   cnt_t           single_cnt;
   cnt_t           double_cnt;

   ecc_pkg::data_t model [`CCM_DEPTH];   // expected data per word index
   logic [31:0]    lfsr;
   int             value_errs;
   int             other_errs;
   int             exp_single;
   int             exp_double;
   ecc_pkg::idx_t  scrub_idx;    // word hit by the single error test
   ecc_pkg::data_t scrub_data;
   ecc_pkg::data_t r_data;       // last read response
   logic           r_single;
   logic           r_double;
   logic           r_addr_err;

   ccm_top i_dut (
      .clk        (clk),
      .rst_l      (rst_l),
      .wr_en      (wr_en),
      .rd_en      (rd_en),
      .addr       (addr),
      .wdata      (wdata),
      .inject     (inject),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .single_err (single_err),
      .double_err (double_err),
      .addr_err   (addr_err),
      .single_cnt (single_cnt),
      .double_cnt (double_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // galois lfsr, one step per bit taken
   function automatic logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      return out;
   endfunction

   function automatic ecc_pkg::data_t rand_bits(input int n);
      ecc_pkg::data_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   function automatic logic [31:0] addr_of(input ecc_pkg::idx_t i);
      return SADR + (32'(i) << 2);
   endfunction

   // step to just after the next rising edge, where inputs change
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic check_data(input string name, input ecc_pkg::data_t exp,
                             input ecc_pkg::data_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, got %h", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, got %h", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, got %h", name, exp, act);
         value_errs++;
      end
   endtask

   task automatic check_counts();
      check_cnt("single_cnt", cnt_t'(exp_single), single_cnt);
      check_cnt("double_cnt", cnt_t'(exp_double), double_cnt);
   endtask

   task automatic check_resp(input ecc_pkg::data_t d, input logic s, input logic db,
                             input logic ae);
      check_data("rd_data", d, r_data);
      check_flag("single_err", s, r_single);
      check_flag("double_err", db, r_double);
      check_flag("addr_err", ae, r_addr_err);
   endtask

   task automatic wait_rd_valid();
      int n;
      n = 0;
      while (!rd_valid && n < 20) begin
         tick();
         n++;
      end
      if (!rd_valid) begin
         $display("no read response within 20 cycles of a read");
         other_errs++;
      end
   endtask

   task automatic write_word(input logic [31:0] a, input ecc_pkg::data_t d,
                             input logic [38:0] m);
      wr_en  = 1'b1;
      addr   = a;
      wdata  = d;
      inject = m;
      tick();
      wr_en  = 1'b0;
      inject = '0;
   endtask

   task automatic read_word(input logic [31:0] a);
      rd_en = 1'b1;
      addr  = a;
      tick();
      rd_en = 1'b0;
      wait_rd_valid();
      r_data     = rd_data;
      r_single   = single_err;
      r_double   = double_err;
      r_addr_err = addr_err;
   endtask

   task automatic test_round_trip();
      ecc_pkg::idx_t idx_list [10];
      for (int i = 0; i < 10; i++) begin
         idx_list[i]        = ecc_pkg::idx_t'(rand_bits(ecc_pkg::IDX_W));
         model[idx_list[i]] = rand_bits(32);
         write_word(addr_of(idx_list[i]), model[idx_list[i]], '0);
      end
      for (int i = 0; i < 10; i++) begin
         read_word(addr_of(idx_list[i]));
         check_resp(model[idx_list[i]], 1'b0, 1'b0, 1'b0);
      end
      check_counts();
   endtask

   task automatic test_single_fix();
      int pos;
      scrub_idx  = ecc_pkg::idx_t'(rand_bits(ecc_pkg::IDX_W));
      scrub_data = rand_bits(32);
      pos        = int'(rand_bits(6)) % 39;   // data and check bits alike
      model[scrub_idx] = scrub_data;
      write_word(addr_of(scrub_idx), scrub_data, 39'd1 << pos);
      read_word(addr_of(scrub_idx));
      exp_single++;
      check_resp(scrub_data, 1'b1, 1'b0, 1'b0);
      check_counts();
   endtask

   task automatic test_scrub();
      repeat (4) tick();   // corrected word goes back in the meantime
      read_word(addr_of(scrub_idx));
      check_resp(scrub_data, 1'b0, 1'b0, 1'b0);
      check_counts();
   endtask

   task automatic test_double_detect();
      int             p1;
      int             p2;
      ecc_pkg::idx_t  ix;
      ecc_pkg::data_t d;
      logic [38:0]    m;
      ix = ecc_pkg::idx_t'(rand_bits(ecc_pkg::IDX_W));
      d  = rand_bits(32);
      p1 = int'(rand_bits(6)) % 39;
      p2 = (p1 + 1 + int'(rand_bits(6)) % 38) % 39;   // never equal to p1
      m  = (39'd1 << p1) | (39'd1 << p2);
      write_word(addr_of(ix), d, m);
      read_word(addr_of(ix));
      exp_double++;
      check_resp(d ^ m[31:0], 1'b0, 1'b1, 1'b0);   // stored word comes back uncorrected
      check_counts();
   endtask

   task automatic test_range();
      logic [31:0]   bad;
      ecc_pkg::idx_t last;
      int            n;
      bad  = SADR + 32'(`CCM_DEPTH * 4);   // first byte above the window
      last = ecc_pkg::idx_t'(`CCM_DEPTH - 1);
      model[last] = rand_bits(32);
      write_word(addr_of(last), model[last], '0);
      model[0] = rand_bits(32);   // same index bits as the bad address
      write_word(addr_of('0), model[0], '0);
      write_word(bad, rand_bits(32), '0);
      n = 0;
      while (!addr_err && n < 5) begin
         tick();
         n++;
      end
      if (!addr_err) begin
         $display("addr_err did not pulse after an out of range write");
         other_errs++;
      end
      tick();
      check_flag("addr_err", 1'b0, addr_err);
      n = 0;
      while (!rd_valid && n < 4) begin
         tick();
         n++;
      end
      if (rd_valid) begin
         $display("a read response appeared after an out of range write");
         other_errs++;
      end
      read_word(bad);
      check_resp('0, 1'b0, 1'b0, 1'b1);
      read_word(addr_of(last));
      check_resp(model[last], 1'b0, 1'b0, 1'b0);
      read_word(addr_of('0));
      check_resp(model[0], 1'b0, 1'b0, 1'b0);
      check_counts();
   endtask

   task automatic test_pipelined();
      ecc_pkg::idx_t ix;
      for (int i = 0; i < 4; i++) begin
         ix        = ecc_pkg::idx_t'(8 + i);
         model[ix] = rand_bits(32);
         write_word(addr_of(ix), model[ix], '0);
      end
      // a read issued in step k answers in step k+2
      for (int k = 0; k < 7; k++) begin
         if (k < 4) begin
            rd_en = 1'b1;
            addr  = addr_of(ecc_pkg::idx_t'(8 + k));
         end else begin
            rd_en = 1'b0;
         end
         if (k >= 2 && k < 6) begin
            ix = ecc_pkg::idx_t'(6 + k);
            check_flag("rd_valid", 1'b1, rd_valid);
            check_data("rd_data", model[ix], rd_data);
            check_flag("single_err", 1'b0, single_err);
            check_flag("double_err", 1'b0, double_err);
         end else begin
            check_flag("rd_valid", 1'b0, rd_valid);
         end
         tick();
      end
      check_counts();
   endtask

   initial begin
      rst_l      = 1'b0;
      wr_en      = 1'b0;
      rd_en      = 1'b0;
      addr       = '0;
      wdata      = '0;
      inject     = '0;
      lfsr       = 32'd42;
      value_errs = 0;
      other_errs = 0;
      exp_single = 0;
      exp_double = 0;
      repeat (5) @(posedge clk);
      #1;
      rst_l = 1'b1;
      tick();
      check_flag("rd_valid", 1'b0, rd_valid);   // state right after reset
      check_flag("addr_err", 1'b0, addr_err);
      check_flag("single_err", 1'b0, single_err);
      check_flag("double_err", 1'b0, double_err);
      check_counts();
      test_round_trip();
      test_single_fix();
      test_scrub();
      test_double_detect();
      test_range();
      test_pipelined();
      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+verilog
verilog/ecc_pkg.sv
verilog/ccm_rd_if.sv
verilog/ecc_encode.sv
verilog/ecc_decode.sv
verilog/ccm_bank.sv
verilog/ccm_resp.sv
verilog/ccm_top.sv
bench/ccm_tb.sv

// File: Makefile
# Verilator build and run of the scratchpad testbench

VERILATOR ?= verilator
TOP       ?= ccm_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --timescale 1ns/100ps
PASS_MSG  ?= Done: no errors

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
